/* source/remap_cfg_pkg.sv */
package remap_cfg_pkg;

  // Upstream read IDs are wide, and only a few of them are in use at any time.
  localparam int unsigned InIdWidth = 8;

  // Downstream read IDs are narrow and densely packed from zero upward.
  localparam int unsigned OutIdWidth = 3;

  // One table entry per upstream ID that may be in flight at the same time.
  localparam int unsigned MaxUniqueIds = 4;

  // Bursts in flight that one upstream ID may have before its requests stall.
  localparam int unsigned MaxTxnsPerId = 2;

  // A table index needs at least one bit, even for a single entry.
  localparam int unsigned IdxWidth = ($clog2(MaxUniqueIds) > 0) ? $clog2(MaxUniqueIds) : 1;

  // The counter must reach MaxTxnsPerId itself, not just MaxTxnsPerId - 1.
  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId + 1);

  typedef logic [InIdWidth-1:0]  in_id_t;
  typedef logic [OutIdWidth-1:0] out_id_t;
  // The downstream ID is this index, zero-extended.
  typedef logic [IdxWidth-1:0]   idx_t;
  typedef logic [CntWidth-1:0]   cnt_t;

endpackage

/* source/axi_rd_pkg.sv */
package axi_rd_pkg;

  // Address and data widths are the same on both ports.
  // Only the ID width differs between upstream and downstream.
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // The AXI response code is one of OKAY, EXOKAY, SLVERR or DECERR.
  typedef logic [1:0] resp_t;

endpackage

/* source/ar_id_allocator.sv */
`timescale 1ns/1ps

module ar_id_allocator (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Upstream AR handshake and ID.
  input  logic                   slv_ar_valid_i,
  input  remap_cfg_pkg::in_id_t  slv_ar_id_i,
  output logic                   slv_ar_ready_o,
  // Downstream AR handshake and remapped ID.
  output logic                   mst_ar_valid_o,
  output remap_cfg_pkg::out_id_t mst_ar_id_o,
  input  logic                   mst_ar_ready_i,
  // Lookup results from the remap table.
  input  logic                   exists_i,
  input  remap_cfg_pkg::idx_t    exists_idx_i,
  input  logic                   exists_full_i,
  input  remap_cfg_pkg::idx_t    free_idx_i,
  input  logic                   full_i,
  // Entry update towards the remap table.
  output logic                   push_o,
  output remap_cfg_pkg::in_id_t  push_in_id_o,
  output remap_cfg_pkg::idx_t    push_idx_o
);

  import remap_cfg_pkg::*;

  // In Ready the request goes through combinationally.
  // In Hold a request that was already counted in the table waits for downstream.
  typedef enum logic {
    Ready,
    Hold
  } state_e;

  state_e state_d;
  state_e state_q;
  idx_t   idx_d;
  idx_t   idx_q;
  idx_t   out_idx;
  logic   admit;

  // A known ID below its limit reuses its entry, so that its bursts keep their order.
  // A new ID needs a free entry.
  assign admit = slv_ar_valid_i &&
                 ((exists_i && !exists_full_i) || (!exists_i && !full_i));

  // The table is always updated with the upstream ID currently presented.
  assign push_in_id_o = slv_ar_id_i;
  assign push_idx_o   = out_idx;

  // The index becomes the downstream ID with zeros in the upper bits.
  assign mst_ar_id_o = out_id_t'(out_idx);

  always_comb begin
    state_d        = state_q;
    idx_d          = idx_q;
    out_idx        = idx_q;
    mst_ar_valid_o = 1'b0;
    slv_ar_ready_o = 1'b0;
    push_o         = 1'b0;

    case (state_q)
      Ready: begin
        // Reuse the index of the matching entry, else take the lowest free one.
        out_idx = exists_i ? exists_idx_i : free_idx_i;
        if (admit) begin
          mst_ar_valid_o = 1'b1;
          slv_ar_ready_o = mst_ar_ready_i;
          // The burst is counted exactly once, here, even if downstream stalls.
          push_o         = 1'b1;
          if (!mst_ar_ready_i) begin
            // Keep the index so the ID cannot change while the request waits.
            idx_d   = out_idx;
            state_d = Hold;
          end
        end
      end

      Hold: begin
        // Replay the stored index without another push.
        mst_ar_valid_o = 1'b1;
        slv_ar_ready_o = mst_ar_ready_i;
        if (mst_ar_ready_i) begin
          state_d = Ready;
        end
      end

      default: begin
        state_d = Ready;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Ready;
    end else begin
      state_q <= state_d;
    end
  end

  // The index of a request that waits in Hold.
  always_ff @(posedge clk_i) begin
    idx_q <= idx_d;
  end

  // A request that downstream has not taken stays on the bus with the same ID.
  // This covers the step from Ready into Hold as well as Hold itself.
  ar_stall_keeps_id: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_id_o)
  );

endmodule

/* source/id_remap_table.sv */
`timescale 1ns/1ps

module id_remap_table (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // An upstream ID is looked up combinationally.
  input  remap_cfg_pkg::in_id_t lookup_in_id_i,
  output logic                  exists_o,
  output remap_cfg_pkg::idx_t   exists_idx_o,
  output logic                  exists_full_o,
  // The lowest free entry is only meaningful while the table is not full.
  output remap_cfg_pkg::idx_t   free_idx_o,
  output logic                  full_o,
  // Count one more burst on an entry.
  input  logic                  push_i,
  input  remap_cfg_pkg::in_id_t push_in_id_i,
  input  remap_cfg_pkg::idx_t   push_idx_i,
  // Count one burst less on an entry.
  input  logic                  pop_i,
  input  remap_cfg_pkg::idx_t   pop_idx_i,
  // Reverse lookup from downstream index to upstream ID.
  input  remap_cfg_pkg::idx_t   lookup_idx_i,
  output remap_cfg_pkg::in_id_t lookup_in_id_o
);

  import remap_cfg_pkg::*;

  // Each entry holds an upstream ID and the number of its bursts in flight.
  // An entry with a zero count is free, whatever ID it still holds.
  in_id_t                  in_id_q [MaxUniqueIds];
  cnt_t                    cnt_d   [MaxUniqueIds];
  cnt_t                    cnt_q   [MaxUniqueIds];
  logic [MaxUniqueIds-1:0] free;
  logic [MaxUniqueIds-1:0] match;

  // Per-entry flags for the free search and the ID match.
  always_comb begin
    for (int i = 0; i < MaxUniqueIds; i++) begin
      free[i]  = (cnt_q[i] == '0);
      match[i] = !free[i] && (in_id_q[i] == lookup_in_id_i);
    end
  end

  // Lowest index wins.
  // Scanning downward lets the last hit be the lowest one.
  always_comb begin
    free_idx_o   = '0;
    exists_idx_o = '0;
    for (int i = MaxUniqueIds - 1; i >= 0; i--) begin
      if (free[i]) begin
        free_idx_o = idx_t'(i);
      end
      if (match[i]) begin
        exists_idx_o = idx_t'(i);
      end
    end
  end

  assign full_o         = ~|free;
  assign exists_o       = |match;
  assign exists_full_o  = exists_o && (cnt_q[exists_idx_o] == cnt_t'(MaxTxnsPerId));
  assign lookup_in_id_o = in_id_q[lookup_idx_i];

  // A push and a pop on the same entry in one cycle cancel out.
  always_comb begin
    for (int i = 0; i < MaxUniqueIds; i++) begin
      cnt_d[i] = cnt_q[i];
      if (push_i && (push_idx_i == idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] + cnt_t'(1);
      end
      if (pop_i && (pop_idx_i == idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '{default: '0};
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // A push records which upstream ID owns the entry.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      in_id_q[push_idx_i] <= push_in_id_i;
    end
  end

  // The allocator must only push to a free entry or to the entry of the same ID below its limit.
  push_is_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (cnt_q[push_idx_i] == '0 || in_id_q[push_idx_i] == push_in_id_i) &&
               (cnt_q[push_idx_i] < cnt_t'(MaxTxnsPerId))
  );

  // A last beat can only come back for a burst that was counted.
  pop_has_burst: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> cnt_q[pop_idx_i] != '0
  );

  // One upstream ID never owns two entries.
  match_is_unique: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(match)
  );

endmodule

/* source/r_id_restorer.sv */
`timescale 1ns/1ps

module r_id_restorer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Downstream R channel.
  input  logic                   mst_r_valid_i,
  input  remap_cfg_pkg::out_id_t mst_r_id_i,
  input  axi_rd_pkg::data_t      mst_r_data_i,
  input  axi_rd_pkg::resp_t      mst_r_resp_i,
  input  logic                   mst_r_last_i,
  output logic                   mst_r_ready_o,
  // The upstream R channel is driven from the slice register.
  output logic                   slv_r_valid_o,
  output remap_cfg_pkg::in_id_t  slv_r_id_o,
  output axi_rd_pkg::data_t      slv_r_data_o,
  output axi_rd_pkg::resp_t      slv_r_resp_o,
  output logic                   slv_r_last_o,
  input  logic                   slv_r_ready_i,
  // Remap table access.
  output remap_cfg_pkg::idx_t    lookup_idx_o,
  input  remap_cfg_pkg::in_id_t  lookup_in_id_i,
  output logic                   pop_o,
  output remap_cfg_pkg::idx_t    pop_idx_o
);

  import remap_cfg_pkg::*;
  import axi_rd_pkg::*;

  logic valid_q;
  idx_t idx_q;
  logic capture;

  // The slice takes a new beat when empty or when its held beat leaves in this cycle.
  assign mst_r_ready_o = !valid_q || slv_r_ready_i;
  assign capture       = mst_r_valid_i && mst_r_ready_o;

  // The upper ID bits are always zero, so the low bits are the table index.
  assign lookup_idx_o  = mst_r_id_i[IdxWidth-1:0];

  assign slv_r_valid_o = valid_q;

  // The burst is done when its last beat leaves upstream, and only then is the entry released.
  assign pop_o     = valid_q && slv_r_ready_i && slv_r_last_o;
  assign pop_idx_o = idx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;
    end else if (slv_r_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // The upstream ID is looked up while the beat enters, since the entry may be freed later.
  always_ff @(posedge clk_i) begin
    if (capture) begin
      slv_r_id_o   <= lookup_in_id_i;
      slv_r_data_o <= mst_r_data_i;
      slv_r_resp_o <= mst_r_resp_i;
      slv_r_last_o <= mst_r_last_i;
      idx_q        <= lookup_idx_o;
    end
  end

  // A beat offered upstream stays put until it is taken.
  r_stall_holds_beat: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    slv_r_valid_o && !slv_r_ready_i |=>
      slv_r_valid_o &&
      $stable({slv_r_id_o, slv_r_data_o, slv_r_resp_o, slv_r_last_o})
  );

endmodule

/* source/id_remap_top.sv */
`timescale 1ns/1ps

module id_remap_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Upstream AR.
  input  logic                   slv_ar_valid_i,
  input  remap_cfg_pkg::in_id_t  slv_ar_id_i,
  input  axi_rd_pkg::addr_t      slv_ar_addr_i,
  output logic                   slv_ar_ready_o,
  // Upstream R.
  input  logic                   slv_r_ready_i,
  output logic                   slv_r_valid_o,
  output remap_cfg_pkg::in_id_t  slv_r_id_o,
  output axi_rd_pkg::data_t      slv_r_data_o,
  output axi_rd_pkg::resp_t      slv_r_resp_o,
  output logic                   slv_r_last_o,
  // Downstream AR.
  output logic                   mst_ar_valid_o,
  output remap_cfg_pkg::out_id_t mst_ar_id_o,
  output axi_rd_pkg::addr_t      mst_ar_addr_o,
  input  logic                   mst_ar_ready_i,
  // Downstream R.
  input  logic                   mst_r_valid_i,
  input  remap_cfg_pkg::out_id_t mst_r_id_i,
  input  axi_rd_pkg::data_t      mst_r_data_i,
  input  axi_rd_pkg::resp_t      mst_r_resp_i,
  input  logic                   mst_r_last_i,
  output logic                   mst_r_ready_o
);

  import remap_cfg_pkg::*;
  import axi_rd_pkg::*;

  // Allocator and table.
  logic   exists;
  idx_t   exists_idx;
  logic   exists_full;
  idx_t   free_idx;
  logic   full;
  logic   push;
  in_id_t push_in_id;
  idx_t   push_idx;

  // Restorer and table.
  idx_t   lookup_idx;
  in_id_t lookup_in_id;
  logic   pop;
  idx_t   pop_idx;

  // Only the ID is remapped, the address is not touched.
  assign mst_ar_addr_o = slv_ar_addr_i;

  // The allocator is the request side.
  ar_id_allocator i_allocator (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_id_i    ( slv_ar_id_i    ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_id_o    ( mst_ar_id_o    ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .exists_i       ( exists         ),
    .exists_idx_i   ( exists_idx     ),
    .exists_full_i  ( exists_full    ),
    .free_idx_i     ( free_idx       ),
    .full_i         ( full           ),
    .push_o         ( push           ),
    .push_in_id_o   ( push_in_id     ),
    .push_idx_o     ( push_idx       )
  );

  // The table is looked up with the upstream AR ID directly.
  id_remap_table i_table (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .lookup_in_id_i ( slv_ar_id_i    ),
    .exists_o       ( exists         ),
    .exists_idx_o   ( exists_idx     ),
    .exists_full_o  ( exists_full    ),
    .free_idx_o     ( free_idx       ),
    .full_o         ( full           ),
    .push_i         ( push           ),
    .push_in_id_i   ( push_in_id     ),
    .push_idx_i     ( push_idx       ),
    .pop_i          ( pop            ),
    .pop_idx_i      ( pop_idx        ),
    .lookup_idx_i   ( lookup_idx     ),
    .lookup_in_id_o ( lookup_in_id   )
  );

  // The restorer is the response side.
  r_id_restorer i_restorer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_id_i     ( mst_r_id_i     ),
    .mst_r_data_i   ( mst_r_data_i   ),
    .mst_r_resp_i   ( mst_r_resp_i   ),
    .mst_r_last_i   ( mst_r_last_i   ),
    .mst_r_ready_o  ( mst_r_ready_o  ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .slv_r_id_o     ( slv_r_id_o     ),
    .slv_r_data_o   ( slv_r_data_o   ),
    .slv_r_resp_o   ( slv_r_resp_o   ),
    .slv_r_last_o   ( slv_r_last_o   ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .lookup_idx_o   ( lookup_idx     ),
    .lookup_in_id_i ( lookup_in_id   ),
    .pop_o          ( pop            ),
    .pop_idx_o      ( pop_idx        )
  );

endmodule

/* sim/tb_id_remap.sv */
`timescale 1ns/1ps

module tb_id_remap;

  import remap_cfg_pkg::*;
  import axi_rd_pkg::*;

  localparam int NumRows       = 14;
  // Cycles a request waits in the responder before its first beat is offered.
  localparam int RespDelay     = 8;
  localparam int PauseCycles   = 3;
  localparam int TimeoutCycles = NumRows * 40;

  // One stimulus row holds the upstream ID, address, downstream AR pause and burst length.
  typedef struct packed {
    in_id_t     id;
    addr_t      addr;
    logic       pause;
    logic [3:0] len;
  } row_t;

  // A request that downstream accepted and that waits for its reply.
  typedef struct packed {
    in_id_t     id;
    idx_t       idx;
    addr_t      addr;
    logic [3:0] len;
    int         t_acc;
  } req_t;

  // A beat that must come out upstream.
  typedef struct packed {
    in_id_t id;
    idx_t   idx;
    data_t  data;
    resp_t  resp;
    logic   last;
  } beat_t;

  logic    clk_i;
  logic    rst_ni;
  logic    slv_ar_valid_i;
  in_id_t  slv_ar_id_i;
  addr_t   slv_ar_addr_i;
  logic    slv_ar_ready_o;
  logic    slv_r_ready_i;
  logic    slv_r_valid_o;
  in_id_t  slv_r_id_o;
  data_t   slv_r_data_o;
  resp_t   slv_r_resp_o;
  logic    slv_r_last_o;
  logic    mst_ar_valid_o;
  out_id_t mst_ar_id_o;
  addr_t   mst_ar_addr_o;
  logic    mst_ar_ready_i;
  logic    mst_r_valid_i;
  out_id_t mst_r_id_i;
  data_t   mst_r_data_i;
  resp_t   mst_r_resp_i;
  logic    mst_r_last_i;
  logic    mst_r_ready_o;

  row_t        rows  [NumRows];
  req_t        req_q [$];
  beat_t       exp_q [$];
  // Reference table with the upstream ID and bursts in flight per downstream index.
  in_id_t      m_id  [MaxUniqueIds];
  int          m_cnt [MaxUniqueIds];
  int          row;
  int          beat;
  int          pause_left;
  int          cycles;
  bit          held;
  idx_t        cur_idx;
  logic [31:0] seed;

  id_remap_top dut (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Read data depends on the address and on the beat number.
  function automatic data_t beat_data(input addr_t a, input int b);
    return (a * 32'h9e37_79b9) + data_t'(b);
  endfunction

  // A known ID reuses its entry up to the limit and a new ID takes the lowest free entry.
  function automatic bit model_pick(input in_id_t id, output idx_t idx);
    idx = '0;
    for (int i = 0; i < MaxUniqueIds; i++) begin
      if (m_cnt[i] != 0 && m_id[i] == id) begin
        idx = idx_t'(i);
        return m_cnt[i] < MaxTxnsPerId;
      end
    end
    for (int i = 0; i < MaxUniqueIds; i++) begin
      if (m_cnt[i] == 0) begin
        idx = idx_t'(i);
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // AR side. The model is consulted with the table state from before this edge.
  task automatic check_ar_side();
    idx_t pick;
    bit   ok;
    req_t r;
    if (held) begin
      // A stalled request keeps its ID and is not counted again.
      check_val("mst_ar_valid_o", mst_ar_valid_o, 1);
      check_val("mst_ar_id_o", mst_ar_id_o, cur_idx);
    end else if (slv_ar_valid_i) begin
      ok = model_pick(slv_ar_id_i, pick);
      check_val("mst_ar_valid_o", mst_ar_valid_o, ok);
      if (ok) begin
        check_val("mst_ar_id_o", mst_ar_id_o, pick);
        cur_idx     = pick;
        m_id[pick]  = slv_ar_id_i;
        m_cnt[pick] = m_cnt[pick] + 1;
      end
    end else begin
      check_val("mst_ar_valid_o", mst_ar_valid_o, 0);
    end
    if (mst_ar_valid_o) begin
      check_val("slv_ar_ready_o", slv_ar_ready_o, mst_ar_ready_i);
      check_val("mst_ar_addr_o", mst_ar_addr_o, rows[row].addr);
    end else begin
      check_val("slv_ar_ready_o", slv_ar_ready_o, 0);
    end
    if (mst_ar_valid_o && mst_ar_ready_i) begin
      r.id    = rows[row].id;
      r.idx   = cur_idx;
      r.addr  = rows[row].addr;
      r.len   = rows[row].len;
      r.t_acc = cycles;
      req_q.push_back(r);
      held = 1'b0;
      row++;
      pause_left = (row < NumRows && rows[row].pause) ? PauseCycles : 0;
    end else if (mst_ar_valid_o) begin
      held = 1'b1;
      if (pause_left > 0) begin
        pause_left--;
      end
    end
  endtask

  // R side. A beat taken downstream must be offered upstream at the very next edge.
  task automatic check_r_side();
    beat_t e;
    req_t  r;
    bit    full;
    full = (exp_q.size() != 0);
    check_val("slv_r_valid_o", slv_r_valid_o, full);
    check_val("mst_r_ready_o", mst_r_ready_o, !full || slv_r_ready_i);
    if (slv_r_valid_o && slv_r_ready_i) begin
      e = exp_q.pop_front();
      check_val("slv_r_id_o", slv_r_id_o, e.id);
      check_val("slv_r_data_o", slv_r_data_o, e.data);
      check_val("slv_r_resp_o", slv_r_resp_o, e.resp);
      check_val("slv_r_last_o", slv_r_last_o, e.last);
      // The entry frees up once the last beat has gone upstream.
      if (e.last) begin
        m_cnt[e.idx] = m_cnt[e.idx] - 1;
      end
    end
    if (mst_r_valid_i && mst_r_ready_o) begin
      r      = req_q[0];
      e.id   = r.id;
      e.idx  = r.idx;
      e.data = beat_data(r.addr, beat);
      e.resp = r.addr[5:4];
      e.last = (beat == int'(r.len) - 1);
      exp_q.push_back(e);
      beat++;
      if (e.last) begin
        void'(req_q.pop_front());
        beat = 0;
      end
    end
  endtask

  task automatic drive_inputs();
    req_t r;
    seed = lcg_next(seed);
    // Upstream takes a beat about three times out of four.
    slv_r_ready_i  <= (seed[31:30] != 2'b00);
    slv_ar_valid_i <= (row < NumRows);
    if (row < NumRows) begin
      slv_ar_id_i   <= rows[row].id;
      slv_ar_addr_i <= rows[row].addr;
    end
    mst_ar_ready_i <= (pause_left == 0);
    // An offered beat stays until the DUT takes it.
    if (!(mst_r_valid_i && !mst_r_ready_o)) begin
      if (req_q.size() != 0 && cycles - req_q[0].t_acc >= RespDelay) begin
        r = req_q[0];
        mst_r_valid_i <= 1'b1;
        mst_r_id_i    <= out_id_t'(r.idx);
        mst_r_data_i  <= beat_data(r.addr, beat);
        mst_r_resp_i  <= r.addr[5:4];
        mst_r_last_i  <= (beat == int'(r.len) - 1);
      end else begin
        mst_r_valid_i <= 1'b0;
      end
    end
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_r_ready_i  = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
    seed           = 32'ha9f8_20d0;
    row            = 0;
    beat           = 0;
    cycles         = 0;
    held           = 1'b0;
    cur_idx        = '0;
    for (int i = 0; i < MaxUniqueIds; i++) begin
      m_cnt[i] = 0;
      m_id[i]  = '0;
    end
    // Row 2 is a third 3c burst and row 6 a fifth distinct ID, so both need a freed entry.
    rows[0]  = '{8'h3c, 32'h1000_0000, 1'b0, 4'd2};
    rows[1]  = '{8'h3c, 32'h1000_0040, 1'b1, 4'd1};
    rows[2]  = '{8'h3c, 32'h1000_0080, 1'b0, 4'd3};
    rows[3]  = '{8'hc5, 32'h2000_0010, 1'b0, 4'd1};
    rows[4]  = '{8'h07, 32'h3000_0020, 1'b0, 4'd4};
    rows[5]  = '{8'hf0, 32'h4000_0030, 1'b0, 4'd2};
    rows[6]  = '{8'h99, 32'h5000_0000, 1'b0, 4'd1};
    rows[7]  = '{8'h07, 32'h3000_0060, 1'b1, 4'd2};
    rows[8]  = '{8'h5a, 32'h6000_0100, 1'b0, 4'd4};
    rows[9]  = '{8'h3c, 32'h1000_00c0, 1'b0, 4'd1};
    rows[10] = '{8'he1, 32'h7000_0200, 1'b1, 4'd3};
    rows[11] = '{8'hc5, 32'h2000_0050, 1'b0, 4'd2};
    rows[12] = '{8'h99, 32'h5000_0040, 1'b0, 4'd1};
    rows[13] = '{8'h12, 32'h8000_0300, 1'b0, 4'd2};
    pause_left = rows[0].pause ? PauseCycles : 0;

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_val("mst_ar_valid_o", mst_ar_valid_o, 0);
    check_val("slv_ar_ready_o", slv_ar_ready_o, 0);
    check_val("slv_r_valid_o", slv_r_valid_o, 0);

    // Outputs are sampled at the edge before this edge's updates, then inputs are driven.
    while (row < NumRows || req_q.size() != 0 || exp_q.size() != 0) begin
      check_ar_side();
      check_r_side();
      drive_inputs();
      @(posedge clk_i);
      cycles++;
      assert (cycles < TimeoutCycles) else begin
        $display("Timeout: the rows were not completed within %0d cycles.", TimeoutCycles);
        stop_run();
      end
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* vlog.f */
source/remap_cfg_pkg.sv
source/axi_rd_pkg.sv
source/ar_id_allocator.sv
source/id_remap_table.sv
source/r_id_restorer.sv
source/id_remap_top.sv
sim/tb_id_remap.sv
